// ==== files.f ====
+incdir+rtl
rtl/fpga_reg_pkg.sv
rtl/entropy_pkg.sv
rtl/fpga_realtime_regs.sv
rtl/log_fifo.sv
rtl/itrng_word_fifo.sv
rtl/etrng_throttle.sv
rtl/fpga_wrapper_top.sv
test/tb_clock_gen.sv
test/tb_fpga_wrapper.sv

// ==== rtl/entropy_pkg.sv ====
// Internal entropy path types
// A queued word is written whole and read back nibble by nibble

`include "fpga_regs_consts.svh"

package entropy_pkg;

    typedef logic [`ITRNG_NIBBLE_W-1:0] itrng_nibble_t;

    // Software view and serializer view of the same word
    typedef union packed {
        logic [`NIBBLES_PER_WORD*`ITRNG_NIBBLE_W-1:0] word;
        itrng_nibble_t [`NIBBLES_PER_WORD-1:0]         nib;  // nib[0] goes out first
    } itrng_word_u;

    // Idle cycles between request pops
    typedef logic [31:0] itrng_divisor_t;

endpackage

// ==== rtl/etrng_throttle.sv ====
// Entropy request throttle
// Lets the core's request through once every divisor+1 cycles as a pop pulse

`include "fpga_regs_consts.svh"

module etrng_throttle (
    input  logic                         core_clk,
    input  logic                         hwif_out,
    input  logic                         etrng_req,
    input  entropy_pkg::itrng_divisor_t  itrng_divisor,
    output logic                         nibble_pop
);

    import entropy_pkg::*;

    itrng_divisor_t counter;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            counter    <= '0;
            nibble_pop <= 1'b0;
        end else if (counter == '0) begin
            nibble_pop <= etrng_req;        // Reloads whether or not the core asks
            counter    <= itrng_divisor;
        end else begin
            nibble_pop <= 1'b0;
            counter    <= counter - 1'b1;
        end
    end

endmodule

// ==== rtl/fpga_realtime_regs.sv ====
// FPGA realtime register block
// Strobe decode, control and divisor registers, cycle counter and registered read data

`include "fpga_regs_consts.svh"

module fpga_realtime_regs (
    input  logic                         core_clk,
    input  logic                         hwif_out,
    input  logic                         reg_wr,
    input  logic                         reg_rd,
    input  fpga_reg_pkg::reg_addr_t      reg_addr,
    input  fpga_reg_pkg::reg_data_t      reg_wdata,
    output fpga_reg_pkg::reg_data_t      reg_rdata,
    output logic                         core_rst_b,
    output logic                         core_pwrgood,
    input  fpga_reg_pkg::log_char_t      log_head,
    input  logic                         log_empty,
    input  logic                         log_full,
    output logic                         log_pop_req,
    input  logic                         itrng_empty,
    input  logic                         itrng_full,
    output logic                         itrng_push,
    output entropy_pkg::itrng_word_u     itrng_word,
    output logic                         itrng_clear,
    output entropy_pkg::itrng_divisor_t  itrng_divisor
);

    import fpga_reg_pkg::*;

    logic [1:0] ctrl;          // bit 1 pwrgood, bit 0 rst_b
    reg_data_t  cycle_count;
    reg_data_t  rd_mux;
    log_char_t  log_shown;
    logic       log_valid;
    logic       wr_control;
    logic       wr_divisor;

    assign wr_control = reg_wr && (reg_addr == `ADDR_CONTROL);
    assign wr_divisor = reg_wr && (reg_addr == `ADDR_ITRNG_DIVISOR);

    assign itrng_push      = reg_wr && (reg_addr == `ADDR_ITRNG_DATA);
    assign itrng_clear     = reg_wr && (reg_addr == `ADDR_ITRNG_RESET);
    assign itrng_word.word = reg_wdata;

    // Valid as seen by this read, pop only then
    assign log_valid   = ~log_empty;
    assign log_pop_req = reg_rd && (reg_addr == `ADDR_LOG_DATA) && log_valid;
    assign log_shown   = log_valid ? log_head : '0;

    assign core_rst_b   = ctrl[0];
    assign core_pwrgood = ctrl[1];

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            ctrl          <= '0;
            itrng_divisor <= '0;
        end else begin
            if (wr_control) ctrl <= reg_wdata[1:0];
            if (wr_divisor) itrng_divisor <= reg_wdata;
        end
    end

    // Counts only while the core is out of reset
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else if (!core_rst_b) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_comb begin
        case (reg_addr)
            `ADDR_CONTROL:       rd_mux = reg_data_t'(ctrl);
            `ADDR_VERSION:       rd_mux = `FPGA_VERSION;
            `ADDR_CYCLE_COUNT:   rd_mux = cycle_count;
            `ADDR_LOG_DATA:      rd_mux = reg_data_t'({log_valid, log_shown});
            `ADDR_LOG_STATUS:    rd_mux = reg_data_t'({log_full, log_empty});
            `ADDR_ITRNG_STATUS:  rd_mux = reg_data_t'({itrng_full, itrng_empty});
            `ADDR_ITRNG_DIVISOR: rd_mux = itrng_divisor;
            default:             rd_mux = '0;  // Write-only and unmapped
        endcase
    end

    // Held until the next read
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

// ==== rtl/fpga_reg_pkg.sv ====
// Register bus and log path types
// Shared by the register block, the log FIFO and the top level

`include "fpga_regs_consts.svh"

package fpga_reg_pkg;

    // Byte address on the register bus
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // One register word, read or write
    typedef logic [`REG_DATA_W-1:0] reg_data_t;

    // Character printed by the core
    typedef logic [7:0] log_char_t;

endpackage

// ==== rtl/fpga_regs_consts.svh ====
// FPGA wrapper constants
// Register map, bus widths, queue depths and the version word

`ifndef FPGA_REGS_CONSTS_SVH
`define FPGA_REGS_CONSTS_SVH

`define REG_ADDR_W          8
`define REG_DATA_W          32

// Byte addresses, one word apart
`define ADDR_CONTROL        8'h00
`define ADDR_VERSION        8'h04
`define ADDR_CYCLE_COUNT    8'h08
`define ADDR_LOG_DATA       8'h10
`define ADDR_LOG_STATUS     8'h14
`define ADDR_ITRNG_DATA     8'h18
`define ADDR_ITRNG_STATUS   8'h1C
`define ADDR_ITRNG_DIVISOR  8'h20
`define ADDR_ITRNG_RESET    8'h24

`define LOG_FIFO_DEPTH      16
`define ITRNG_FIFO_DEPTH    4
`define NIBBLES_PER_WORD    8
`define ITRNG_NIBBLE_W      4

`define FPGA_VERSION        32'h5A17_0100

`endif

// ==== rtl/fpga_wrapper_top.sv ====
// FPGA wrapper top level
// Ties the register block to the log FIFO and the entropy throttle and queue

`include "fpga_regs_consts.svh"

module fpga_wrapper_top (
    input  logic                        core_clk,
    input  logic                        hwif_out,
    input  logic                        reg_wr,
    input  logic                        reg_rd,
    input  fpga_reg_pkg::reg_addr_t     reg_addr,
    input  fpga_reg_pkg::reg_data_t     reg_wdata,
    output fpga_reg_pkg::reg_data_t     reg_rdata,
    output logic                        core_rst_b,
    output logic                        core_pwrgood,
    input  logic                        log_wr,
    input  fpga_reg_pkg::log_char_t     log_char,
    input  logic                        etrng_req,
    output entropy_pkg::itrng_nibble_t  itrng_data,
    output logic                        itrng_valid
);

    import fpga_reg_pkg::*;
    import entropy_pkg::*;

    log_char_t      log_head;
    logic           log_empty;
    logic           log_full;
    logic           log_pop_req;
    logic           itrng_push;
    itrng_word_u    itrng_word;
    logic           itrng_clear;
    itrng_divisor_t itrng_divisor;
    logic           itrng_empty;
    logic           itrng_full;
    logic           nibble_pop;

    fpga_realtime_regs regs (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .core_rst_b    (core_rst_b),
        .core_pwrgood  (core_pwrgood),
        .log_head      (log_head),
        .log_empty     (log_empty),
        .log_full      (log_full),
        .log_pop_req   (log_pop_req),
        .itrng_empty   (itrng_empty),
        .itrng_full    (itrng_full),
        .itrng_push    (itrng_push),
        .itrng_word    (itrng_word),
        .itrng_clear   (itrng_clear),
        .itrng_divisor (itrng_divisor)
    );

    // Characters printed by the core
    log_fifo log_q (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .log_wr      (log_wr),
        .log_char    (log_char),
        .log_pop_req (log_pop_req),
        .log_head    (log_head),
        .log_empty   (log_empty),
        .log_full    (log_full)
    );

    etrng_throttle throttle (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .etrng_req     (etrng_req),
        .itrng_divisor (itrng_divisor),
        .nibble_pop    (nibble_pop)
    );

    itrng_word_fifo itrng_q (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .itrng_push  (itrng_push),
        .itrng_word  (itrng_word),
        .itrng_clear (itrng_clear),
        .nibble_pop  (nibble_pop),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid),
        .itrng_empty (itrng_empty),
        .itrng_full  (itrng_full)
    );

endmodule

// ==== rtl/itrng_word_fifo.sv ====
// Internal entropy word queue
// Holds software words and hands them out as nibbles, least significant first

`include "fpga_regs_consts.svh"

module itrng_word_fifo (
    input  logic                        core_clk,
    input  logic                        hwif_out,
    input  logic                        itrng_push,
    input  entropy_pkg::itrng_word_u    itrng_word,
    input  logic                        itrng_clear,
    input  logic                        nibble_pop,
    output entropy_pkg::itrng_nibble_t  itrng_data,
    output logic                        itrng_valid,
    output logic                        itrng_empty,
    output logic                        itrng_full
);

    import entropy_pkg::*;

    localparam int unsigned DEPTH = `ITRNG_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam int unsigned IDX_W = $clog2(`NIBBLES_PER_WORD);

    itrng_word_u      mem [DEPTH];
    itrng_word_u      head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [IDX_W-1:0] nib_idx;     // Next nibble of the head word
    logic             do_push;
    logic             do_pop;
    logic             retire;

    assign itrng_empty = (count == '0);
    assign itrng_full  = (count == CNT_W'(DEPTH));
    assign head        = mem[rd_ptr];

    assign do_push = itrng_push && !itrng_full;
    assign do_pop  = nibble_pop && !itrng_empty;
    assign retire  = do_pop && (nib_idx == IDX_W'(`NIBBLES_PER_WORD - 1));

    always_ff @(posedge core_clk) begin
        if (do_push) mem[wr_ptr] <= itrng_word;
        if (do_pop) itrng_data <= head.nib[nib_idx];
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else if (itrng_clear) begin
            // Clear wins over a push or pop in the same cycle
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= do_pop;
            if (do_pop) nib_idx <= nib_idx + 1'b1;     // Wraps after the last nibble
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (retire) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(do_push) - CNT_W'(retire);
        end
    end

endmodule

// ==== rtl/log_fifo.sv ====
// Log character FIFO
// Circular buffer with fall-through head, filled by the core and drained by register reads

`include "fpga_regs_consts.svh"

module log_fifo (
    input  logic                     core_clk,
    input  logic                     hwif_out,
    input  logic                     log_wr,
    input  fpga_reg_pkg::log_char_t  log_char,
    input  logic                     log_pop_req,
    output fpga_reg_pkg::log_char_t  log_head,
    output logic                     log_empty,
    output logic                     log_full
);

    import fpga_reg_pkg::*;

    localparam int unsigned DEPTH = `LOG_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    log_char_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign log_empty = (count == '0);
    assign log_full  = (count == CNT_W'(DEPTH));
    assign do_wr     = log_wr && !log_full;       // Dropped when full
    assign do_rd     = log_pop_req && !log_empty;
    assign log_head  = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (do_wr) mem[wr_ptr] <= log_char;
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only when the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -f files.f --top-module tb_fpga_wrapper -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep "=== PASS ===" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset
// 20 ns core clock, reset held low for the first 3 cycles

module tb_clock_gen (
    output logic core_clk,
    output logic hwif_out
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    initial begin
        hwif_out = 1'b0;
        repeat (3) @(posedge core_clk);
        #1 hwif_out = 1'b1;     // Released off the edge
    end

endmodule

// ==== test/tb_fpga_wrapper.sv ====
// Testbench for the FPGA wrapper
// Random register, log and entropy traffic checked against a model of the queues and counter

`include "fpga_regs_consts.svh"

module tb_fpga_wrapper;
    timeunit 1ns;
    timeprecision 100ps;

    import fpga_reg_pkg::*;
    import entropy_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic          core_clk;
    logic          hwif_out;
    logic          reg_wr;
    logic          reg_rd;
    reg_addr_t     reg_addr;
    reg_data_t     reg_wdata;
    reg_data_t     reg_rdata;
    logic          core_rst_b;
    logic          core_pwrgood;
    logic          log_wr;
    log_char_t     log_char;
    logic          etrng_req;
    itrng_nibble_t itrng_data;
    logic          itrng_valid;

    integer    seed = 74;
    int        checks = 0;
    int        errors = 0;
    log_char_t log_model[$];     // Characters the log should still hold
    reg_data_t word_model[$];    // Words the entropy queue should still hold

    tb_clock_gen clk_gen (.core_clk(core_clk), .hwif_out(hwif_out));

    fpga_wrapper_top uut (.*);

    function automatic int unsigned rand_below(int unsigned lim);
        reg_data_t r;
        r = $random(seed);
        return r % lim;
    endfunction

    task automatic check_data(string name, reg_data_t exp, reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_nibble(string name, itrng_nibble_t exp, itrng_nibble_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic check_level(string name, bit exp, bit act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge core_clk);
        #2;
    endtask

    task automatic reg_write(reg_addr_t addr, reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        tick();
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(reg_addr_t addr, output reg_data_t data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        tick();
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (hwif_out !== 1'b1 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (hwif_out !== 1'b1) begin
            errors++;
            $display("Timed out waiting for reset to be released");
        end
        tick();
    endtask

    task automatic wait_valid(output int cycles);
        cycles = 0;
        do begin
            tick();
            cycles++;
        end while (itrng_valid !== 1'b1 && cycles < WAIT_LIMIT);
        if (itrng_valid !== 1'b1) begin
            errors++;
            $display("Timed out waiting for itrng_valid after %0d cycles", cycles);
        end
    endtask

    // Status word holds full in bit 1 and empty in bit 0
    task automatic expect_status(string name, reg_addr_t addr, int count, int depth);
        reg_data_t rd;
        reg_read(addr, rd);
        check_data(name, reg_data_t'({count == depth, count == 0}), rd);
    endtask

    task automatic push_words(int n);
        reg_data_t w;
        for (int i = 0; i < n; i++) begin
            w = $random(seed);
            reg_write(`ADDR_ITRNG_DATA, w);
            if (word_model.size() < `ITRNG_FIFO_DEPTH) word_model.push_back(w);
        end
    endtask

    // Gap between valids is checked from the second nibble on
    task automatic drain_words(reg_data_t gap);
        reg_data_t w;
        int        cycles;
        bit        first;
        first     = 1'b1;
        etrng_req = 1'b1;
        while (word_model.size() > 0) begin
            w = word_model.pop_front();
            for (int k = 0; k < `NIBBLES_PER_WORD; k++) begin
                wait_valid(cycles);
                if (!first) check_data("itrng_gap", gap, reg_data_t'(cycles));
                check_nibble("itrng_nibble", itrng_nibble_t'(w >> (4 * k)), itrng_data);
                first = 1'b0;
            end
        end
    endtask

    task automatic expect_idle(int cycles);
        repeat (cycles) begin
            tick();
            check_level("itrng_idle", 1'b0, itrng_valid);
        end
    endtask

    task automatic test_done(string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        reg_data_t   rd;
        reg_data_t   v;
        reg_data_t   c1;
        reg_data_t   c2;
        int unsigned gap;
        int          n;
        log_char_t   ch;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        log_wr    = 1'b0;
        log_char  = '0;
        etrng_req = 1'b0;
        wait_reset();

        check_level("rst_b_after_reset", 1'b0, core_rst_b);
        check_level("pwrgood_after_reset", 1'b0, core_pwrgood);
        reg_read(`ADDR_VERSION, rd);
        check_data("version", `FPGA_VERSION, rd);
        reg_read(8'h3C, rd);
        check_data("unmapped", '0, rd);
        test_done("reset_defaults");

        for (int i = 0; i < 4; i++) begin
            v = rand_below(4);
            reg_write(`ADDR_CONTROL, v);
            check_level("ctrl_rst_b", v[0], core_rst_b);
            check_level("ctrl_pwrgood", v[1], core_pwrgood);
        end
        reg_write(`ADDR_CONTROL, 32'h3);
        reg_read(`ADDR_CYCLE_COUNT, c1);
        gap = 1 + rand_below(20);
        repeat (gap - 1) tick();
        reg_read(`ADDR_CYCLE_COUNT, c2);
        check_data("cycle_gap", gap, c2 - c1);
        reg_write(`ADDR_CONTROL, '0);
        tick();
        reg_read(`ADDR_CYCLE_COUNT, rd);
        check_data("cycle_in_reset", '0, rd);
        test_done("control_and_counter");

        // First round overflows the log, second one refills it after the empty read
        for (int round = 0; round < 2; round++) begin
            n = (round == 0) ? 17 + int'(rand_below(4)) : 1 + int'(rand_below(8));
            for (int i = 0; i < n; i++) begin
                ch       = log_char_t'(rand_below(256));
                log_wr   = 1'b1;
                log_char = ch;
                if (log_model.size() < `LOG_FIFO_DEPTH) log_model.push_back(ch);
                tick();
            end
            log_wr = 1'b0;
            expect_status("log_status_filled", `ADDR_LOG_STATUS, log_model.size(),
                          `LOG_FIFO_DEPTH);
            while (log_model.size() > 0) begin
                ch = log_model.pop_front();
                reg_read(`ADDR_LOG_DATA, rd);
                check_data("log_data", {23'h0, 1'b1, ch}, rd);
            end
            reg_read(`ADDR_LOG_DATA, rd);
            check_level("log_empty_valid", 1'b0, rd[8]);
            expect_status("log_status_drained", `ADDR_LOG_STATUS, 0, `LOG_FIFO_DEPTH);
        end
        test_done("log_fifo");

        reg_write(`ADDR_ITRNG_DIVISOR, '0);
        push_words(`ITRNG_FIFO_DEPTH + 1 + int'(rand_below(3)));
        expect_status("itrng_status_filled", `ADDR_ITRNG_STATUS, word_model.size(),
                      `ITRNG_FIFO_DEPTH);
        drain_words(1);
        expect_idle(8);
        etrng_req = 1'b0;
        expect_status("itrng_status_drained", `ADDR_ITRNG_STATUS, 0, `ITRNG_FIFO_DEPTH);
        push_words(3);
        expect_status("itrng_status_partial", `ADDR_ITRNG_STATUS, word_model.size(),
                      `ITRNG_FIFO_DEPTH);
        reg_write(`ADDR_ITRNG_RESET, '0);
        word_model.delete();
        expect_status("itrng_status_cleared", `ADDR_ITRNG_STATUS, 0, `ITRNG_FIFO_DEPTH);
        etrng_req = 1'b1;
        expect_idle(8);
        etrng_req = 1'b0;
        test_done("itrng_queue");

        gap = 1 + rand_below(7);
        reg_write(`ADDR_ITRNG_DIVISOR, gap);
        push_words(2);
        drain_words(gap + 1);
        expect_idle(2 * gap + 4);
        etrng_req = 1'b0;
        test_done("itrng_throttle");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
